// ==== flist.f ====
rtl/i2c_master_pkg.sv
rtl/i2c_scl_monitor.sv
rtl/i2c_master_fsm.sv
rtl/i2c_master_top.sv
sim/i2c_bus_model.sv
sim/tb_i2c_master.sv

// ==== rtl/i2c_master_fsm.sv ====
`timescale 1ns/1ps

module i2c_master_fsm #(
    parameter int START_DELAY = 6
) (
    input  logic                          i2c_core_clk_i,
    input  logic                          reset_ni,
    input  logic                          enable_i,
    input  logic                          repeat_start_i,
    input  logic                          rw_i,           // 1 is read
    input  i2c_master_pkg::fifo_status_t  fifo_status_i,
    input  logic                          i2c_sda_i,
    input  logic                          i2c_scl_i,
    input  i2c_master_pkg::scl_event_t    scl_event_i,
    output i2c_master_pkg::bit_phase_e    bit_phase_o,
    output i2c_master_pkg::line_ctrl_t    line_ctrl_o,
    output i2c_master_pkg::fifo_strobe_t  fifo_strobe_o
);

    localparam int IDLE_CNT_W = (START_DELAY < 1) ? 1 : $clog2(START_DELAY + 1);
    localparam logic [IDLE_CNT_W-1:0] IDLE_CNT_MAX = IDLE_CNT_W'(START_DELAY);

    i2c_master_pkg::i2c_state_e state_q;
    i2c_master_pkg::i2c_state_e state_d;

    logic [IDLE_CNT_W-1:0] idle_cnt_q;
    logic                  ack_ok;      // slave pulled sda low
    logic                  tx_pop_q;
    logic                  rx_push_q;

    assign ack_ok = ~i2c_sda_i;

    // ------------------------------
    // state register
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q <= i2c_master_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            i2c_master_pkg::IDLE: begin
                if (enable_i && idle_cnt_q == IDLE_CNT_MAX) state_d = i2c_master_pkg::START;
            end
            i2c_master_pkg::START: begin
                // leave once the generator has pulled scl low
                if (!i2c_scl_i) state_d = i2c_master_pkg::ADDRESS;
            end
            i2c_master_pkg::ADDRESS: begin
                if (scl_event_i.bits_done && scl_event_i.fall) begin
                    state_d = i2c_master_pkg::READ_ACK;
                end
            end
            i2c_master_pkg::READ_ACK: begin
                if (scl_event_i.fall) begin
                    if (ack_ok && rw_i && !fifo_status_i.full) begin
                        state_d = i2c_master_pkg::READ_DATA;
                    end else if (ack_ok && !rw_i && !fifo_status_i.empty) begin
                        state_d = i2c_master_pkg::WRITE_DATA;
                    end else begin
                        state_d = i2c_master_pkg::STOP;  // nack or no room
                    end
                end
            end
            i2c_master_pkg::WRITE_DATA: begin
                if (scl_event_i.bits_done && scl_event_i.fall) begin
                    state_d = i2c_master_pkg::READ_LATER_ACK;
                end
            end
            i2c_master_pkg::READ_LATER_ACK: begin
                if (scl_event_i.fall) begin
                    if (repeat_start_i) begin
                        state_d = i2c_master_pkg::REPEAT_START;
                    end else if (ack_ok && !fifo_status_i.empty) begin
                        state_d = i2c_master_pkg::WRITE_DATA;
                    end else begin
                        state_d = i2c_master_pkg::STOP;
                    end
                end
            end
            i2c_master_pkg::READ_DATA: begin
                if (scl_event_i.bits_done && scl_event_i.fall) begin
                    state_d = i2c_master_pkg::WRITE_ACK;
                end
            end
            i2c_master_pkg::WRITE_ACK: begin
                if (scl_event_i.fall) begin
                    if (repeat_start_i) begin
                        state_d = i2c_master_pkg::REPEAT_START;
                    end else if (!fifo_status_i.full) begin
                        state_d = i2c_master_pkg::READ_DATA;
                    end else begin
                        state_d = i2c_master_pkg::STOP;
                    end
                end
            end
            i2c_master_pkg::REPEAT_START: begin
                if (scl_event_i.rise) state_d = i2c_master_pkg::START;
            end
            i2c_master_pkg::STOP: begin
                if (scl_event_i.rise) state_d = i2c_master_pkg::IDLE;
            end
            default: state_d = i2c_master_pkg::IDLE;
        endcase
    end

    // ------------------------------
    // idle delay and fifo strobes
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            idle_cnt_q <= '0;
            tx_pop_q   <= 1'b0;
            rx_push_q  <= 1'b0;
        end else begin
            if (state_q != i2c_master_pkg::IDLE) begin
                idle_cnt_q <= '0;
            end else if (idle_cnt_q != IDLE_CNT_MAX) begin
                idle_cnt_q <= idle_cnt_q + 1'b1;  // holds once the delay is met
            end
            // next byte out of the tx fifo during the slave ack
            tx_pop_q  <= (state_q == i2c_master_pkg::READ_LATER_ACK) && scl_event_i.rise;
            // received byte into the rx fifo during our ack
            rx_push_q <= (state_q == i2c_master_pkg::WRITE_ACK) && scl_event_i.rise;
        end
    end

    assign fifo_strobe_o.tx_pop  = tx_pop_q;
    assign fifo_strobe_o.rx_push = rx_push_q;

    // shift phase for the monitor
    always_comb begin
        unique case (state_q)
            i2c_master_pkg::ADDRESS,
            i2c_master_pkg::WRITE_DATA: bit_phase_o = i2c_master_pkg::BIT_PHASE_TX;
            i2c_master_pkg::READ_DATA:  bit_phase_o = i2c_master_pkg::BIT_PHASE_RX;
            default:                    bit_phase_o = i2c_master_pkg::BIT_PHASE_NONE;
        endcase
    end

    // ------------------------------
    // line drive decode
    always_comb begin
        line_ctrl_o = '0;
        unique case (state_q)
            i2c_master_pkg::START,
            i2c_master_pkg::WRITE_ACK: begin
                line_ctrl_o.clk_en     = 1'b1;
                line_ctrl_o.sda_low_en = 1'b1;  // start condition or our ack
                line_ctrl_o.sda_en     = 1'b1;
                line_ctrl_o.scl_en     = 1'b1;
            end
            i2c_master_pkg::ADDRESS: begin
                line_ctrl_o.clk_en        = 1'b1;
                line_ctrl_o.write_addr_en = ~i2c_scl_i;  // change sda only while scl low
                line_ctrl_o.sda_en        = 1'b1;
                line_ctrl_o.scl_en        = 1'b1;
            end
            i2c_master_pkg::WRITE_DATA: begin
                line_ctrl_o.clk_en        = 1'b1;
                line_ctrl_o.write_data_en = ~i2c_scl_i;
                line_ctrl_o.sda_en        = 1'b1;
                line_ctrl_o.scl_en        = 1'b1;
            end
            i2c_master_pkg::READ_DATA: begin
                line_ctrl_o.clk_en          = 1'b1;
                line_ctrl_o.receive_data_en = i2c_scl_i;  // sample while scl high
                line_ctrl_o.scl_en          = 1'b1;
            end
            i2c_master_pkg::READ_ACK,
            i2c_master_pkg::READ_LATER_ACK,
            i2c_master_pkg::REPEAT_START: begin
                // sda released to the slave or pulled up for the restart
                line_ctrl_o.clk_en = 1'b1;
                line_ctrl_o.scl_en = 1'b1;
            end
            i2c_master_pkg::STOP: begin
                line_ctrl_o.sda_low_en = 1'b1;
                line_ctrl_o.sda_en     = 1'b1;
                line_ctrl_o.scl_en     = 1'b1;
            end
            default: line_ctrl_o = '0;
        endcase
    end

    // ------------------------------
    a_strobe_excl: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        !(fifo_strobe_o.tx_pop && fifo_strobe_o.rx_push)
    ) else $error("tx pop and rx push in the same cycle");

    a_state_legal: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        state_q inside {i2c_master_pkg::IDLE, i2c_master_pkg::START,
                        i2c_master_pkg::ADDRESS, i2c_master_pkg::READ_ACK,
                        i2c_master_pkg::WRITE_DATA, i2c_master_pkg::READ_LATER_ACK,
                        i2c_master_pkg::READ_DATA, i2c_master_pkg::WRITE_ACK,
                        i2c_master_pkg::REPEAT_START, i2c_master_pkg::STOP}
    ) else $error("illegal state encoding %b", state_q);

endmodule

// ==== rtl/i2c_master_pkg.sv ====
package i2c_master_pkg;

    // width of the bit index handed to the data path
    localparam int BIT_IDX_W = 4;

    // ------------------------------
    // transaction states
    typedef enum logic [3:0] {
        IDLE           = 4'b0000,
        START          = 4'b0001,
        ADDRESS        = 4'b0010,
        READ_ACK       = 4'b0011,  // slave ack after the address byte
        WRITE_DATA     = 4'b0100,
        READ_LATER_ACK = 4'b0101,  // slave ack after a data byte
        READ_DATA      = 4'b0110,
        WRITE_ACK      = 4'b0111,  // master ack after a received byte
        REPEAT_START   = 4'b1000,
        STOP           = 4'b1001
    } i2c_state_e;

    // which scl edge moves the bit index
    typedef enum logic [1:0] {
        BIT_PHASE_NONE = 2'b00,  // reload while not shifting
        BIT_PHASE_TX   = 2'b01,  // step on rising scl
        BIT_PHASE_RX   = 2'b10   // step on falling scl
    } bit_phase_e;

    // ------------------------------
    // scl edges and byte completion from the monitor
    typedef struct packed {
        logic rise;
        logic fall;
        logic bits_done;  // all rising edges of a byte seen
    } scl_event_t;

    // flags from the external fifos
    typedef struct packed {
        logic full;   // receive side
        logic empty;  // transmit side
    } fifo_status_t;

    // line drive enables for the pads and the shift registers
    typedef struct packed {
        logic clk_en;
        logic sda_low_en;
        logic write_data_en;
        logic write_addr_en;
        logic receive_data_en;
        logic sda_en;
        logic scl_en;
    } line_ctrl_t;

    // one-cycle fifo strobes
    typedef struct packed {
        logic tx_pop;
        logic rx_push;
    } fifo_strobe_t;

endpackage

// ==== rtl/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top #(
    parameter int DATA_BITS   = 8,  // bits per byte
    parameter int START_DELAY = 6   // idle core clocks before start
) (
    input  logic                                 i2c_core_clk_i,
    input  logic                                 reset_ni,
    input  logic                                 enable_i,
    input  logic                                 repeat_start_i,
    input  logic                                 rw_i,
    input  i2c_master_pkg::fifo_status_t         fifo_status_i,
    input  logic                                 i2c_sda_i,
    input  logic                                 i2c_scl_i,
    output i2c_master_pkg::line_ctrl_t           line_ctrl_o,
    output logic [i2c_master_pkg::BIT_IDX_W-1:0] count_bit_o,
    output i2c_master_pkg::fifo_strobe_t         fifo_strobe_o
);

    // ------------------------------
    // monitor <-> state machine
    i2c_master_pkg::bit_phase_e bit_phase;
    i2c_master_pkg::scl_event_t scl_event;

    // scl edges, byte completion and bit index
    i2c_scl_monitor #(
        .DATA_BITS (DATA_BITS)
    ) u_scl_monitor (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .bit_phase_i    (bit_phase),
        .scl_event_o    (scl_event),
        .count_bit_o    (count_bit_o)
    );

    // transaction control
    i2c_master_fsm #(
        .START_DELAY (START_DELAY)
    ) u_master_fsm (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .enable_i       (enable_i),
        .repeat_start_i (repeat_start_i),
        .rw_i           (rw_i),
        .fifo_status_i  (fifo_status_i),
        .i2c_sda_i      (i2c_sda_i),
        .i2c_scl_i      (i2c_scl_i),
        .scl_event_i    (scl_event),
        .bit_phase_o    (bit_phase),
        .line_ctrl_o    (line_ctrl_o),
        .fifo_strobe_o  (fifo_strobe_o)
    );

endmodule

// ==== rtl/i2c_scl_monitor.sv ====
`timescale 1ns/1ps

module i2c_scl_monitor #(
    parameter int DATA_BITS = 8
) (
    input  logic                                 i2c_core_clk_i,
    input  logic                                 reset_ni,
    input  logic                                 i2c_scl_i,
    input  i2c_master_pkg::bit_phase_e           bit_phase_i,
    output i2c_master_pkg::scl_event_t           scl_event_o,
    output logic [i2c_master_pkg::BIT_IDX_W-1:0] count_bit_o
);

    localparam int CNT_W = $clog2(DATA_BITS + 1);
    localparam logic [i2c_master_pkg::BIT_IDX_W-1:0] LAST_IDX =
        i2c_master_pkg::BIT_IDX_W'(DATA_BITS - 1);

    logic             scl_q;       // scl one core clock ago
    logic             scl_rise;
    logic             scl_fall;
    logic [CNT_W-1:0] edge_cnt_q;  // rising edges in the current phase
    logic             bits_done_q;
    logic [i2c_master_pkg::BIT_IDX_W-1:0] bit_idx_q;

    // ------------------------------
    // edge detect
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_q <= 1'b1;  // bus idles high
        end else begin
            scl_q <= i2c_scl_i;
        end
    end

    assign scl_rise = i2c_scl_i & ~scl_q;
    assign scl_fall = ~i2c_scl_i & scl_q;

    // ------------------------------
    // rising edge counter, saturates once the byte is complete
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            edge_cnt_q  <= '0;
            bits_done_q <= 1'b0;
        end else begin
            if (bit_phase_i == i2c_master_pkg::BIT_PHASE_NONE) begin
                edge_cnt_q <= '0;
            end else if (scl_rise && edge_cnt_q != CNT_W'(DATA_BITS)) begin
                edge_cnt_q <= edge_cnt_q + 1'b1;
            end
            bits_done_q <= (bit_phase_i != i2c_master_pkg::BIT_PHASE_NONE) &&
                           (edge_cnt_q == CNT_W'(DATA_BITS));
        end
    end

    // ------------------------------
    // bit index, msb first, stops at 0
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            bit_idx_q <= LAST_IDX;
        end else begin
            unique case (bit_phase_i)
                i2c_master_pkg::BIT_PHASE_TX: begin
                    if (scl_rise && bit_idx_q != '0) bit_idx_q <= bit_idx_q - 1'b1;
                end
                i2c_master_pkg::BIT_PHASE_RX: begin
                    if (scl_fall && bit_idx_q != '0) bit_idx_q <= bit_idx_q - 1'b1;
                end
                default: bit_idx_q <= LAST_IDX;  // reload between bytes
            endcase
        end
    end

    assign scl_event_o.rise      = scl_rise;
    assign scl_event_o.fall      = scl_fall;
    assign scl_event_o.bits_done = bits_done_q;
    assign count_bit_o           = bit_idx_q;

    // index handed to the data path stays inside the byte
    a_bit_idx_range: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        count_bit_o <= LAST_IDX
    ) else $error("bit index %0d beyond byte width", count_bit_o);

endmodule

// ==== sim/i2c_bus_model.sv ====
`timescale 1ns/1ps

module i2c_bus_model #(
    parameter int DATA_BITS = 8
) (
    input  logic                                 i2c_core_clk_i,
    input  logic                                 reset_ni,
    input  i2c_master_pkg::i2c_state_e           state_i,
    input  i2c_master_pkg::line_ctrl_t           line_ctrl_i,
    input  i2c_master_pkg::fifo_strobe_t         fifo_strobe_i,
    input  logic [i2c_master_pkg::BIT_IDX_W-1:0] count_bit_i,
    input  logic                                 addr_ack_i,
    input  logic [15:0]                          nack_mask_i,
    input  int                                   tx_bytes_i,
    input  int                                   rx_space_i,
    input  int                                   rep_byte_i,
    output logic                                 i2c_scl_o,
    output logic                                 i2c_sda_o,
    output logic                                 repeat_start_o,
    output i2c_master_pkg::fifo_status_t         fifo_status_o,
    output int                                   pops_o,
    output int                                   pushes_o,
    output int                                   starts_o,
    output int                                   stops_o,
    output logic [1:0]                           err_o  // 0 bit index, 1 start drive
);

    int                         scl_div;
    int                         data_byte;  // data bytes begun so far
    int                         pops_n;
    int                         pushes_n;
    logic                       scl_q;      // scl as driven one core clock ago
    logic                       step_due;   // index edge seen by the master last cycle
    i2c_master_pkg::i2c_state_e prev_state;
    logic [i2c_master_pkg::BIT_IDX_W-1:0] prev_idx;

    function automatic logic is_shift(i2c_master_pkg::i2c_state_e s);
        return s inside {i2c_master_pkg::ADDRESS, i2c_master_pkg::WRITE_DATA,
                         i2c_master_pkg::READ_DATA};
    endfunction

    initial begin
        i2c_scl_o      = 1'b1;
        i2c_sda_o      = 1'b1;
        repeat_start_o = 1'b0;
        fifo_status_o  = '0;
    end

    always @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            i2c_scl_o      <= 1'b1;
            i2c_sda_o      <= 1'b1;
            repeat_start_o <= 1'b0;
            fifo_status_o  <= '0;
            scl_div        <= 0;
            data_byte      <= 0;
            {pops_o, pushes_o, starts_o, stops_o} <= '0;
            scl_q          <= 1'b1;
            step_due       <= 1'b0;
            prev_state     <= i2c_master_pkg::IDLE;
            prev_idx       <= (i2c_master_pkg::BIT_IDX_W)'(DATA_BITS - 1);
            err_o          <= '0;
        end else begin
            // ------------------------------
            // scl toggles every 4 core clocks while enabled
            if (!line_ctrl_i.clk_en) begin
                scl_div   <= 0;
                i2c_scl_o <= 1'b1;
            end else if (scl_div == 3) begin
                scl_div   <= 0;
                i2c_scl_o <= ~i2c_scl_o;
            end else begin
                scl_div <= scl_div + 1;
            end
            // fifo occupancy from strobes seen
            pops_n   = pops_o + int'(fifo_strobe_i.tx_pop);
            pushes_n = pushes_o + int'(fifo_strobe_i.rx_push);
            pops_o   <= pops_n;
            pushes_o <= pushes_n;
            fifo_status_o.empty <= (pops_n >= tx_bytes_i);
            fifo_status_o.full  <= (pushes_n >= rx_space_i);
            // slave acknowledge on sda
            case (state_i)
                i2c_master_pkg::READ_ACK:       i2c_sda_o <= ~addr_ack_i;
                i2c_master_pkg::READ_LATER_ACK: i2c_sda_o <= (data_byte > 0) &&
                                                             nack_mask_i[data_byte - 1];
                default:                        i2c_sda_o <= 1'b1;
            endcase
            repeat_start_o <= (rep_byte_i != 0) && (data_byte == rep_byte_i);
            // ------------------------------
            // state entries
            prev_state <= state_i;
            if (state_i != prev_state) begin
                if (state_i inside {i2c_master_pkg::WRITE_DATA, i2c_master_pkg::READ_DATA})
                    data_byte <= data_byte + 1;
                if (state_i == i2c_master_pkg::START) starts_o <= starts_o + 1;
                if (state_i == i2c_master_pkg::STOP)  stops_o  <= stops_o + 1;
            end
            if (state_i == i2c_master_pkg::START &&
                !(line_ctrl_i.sda_low_en && line_ctrl_i.sda_en && line_ctrl_i.scl_en))
                err_o[1] <= 1'b1;
            // tx bytes step on rising scl, rx bytes on falling scl
            scl_q    <= i2c_scl_o;
            step_due <= ((state_i inside {i2c_master_pkg::ADDRESS,
                                          i2c_master_pkg::WRITE_DATA}) &&
                         i2c_scl_o && !scl_q) ||
                        ((state_i == i2c_master_pkg::READ_DATA) && !i2c_scl_o && scl_q);
            // bit index walks down by one from the top bit to 0 in each byte
            if (is_shift(state_i)) begin
                if (state_i != prev_state) begin
                    if (count_bit_i != (i2c_master_pkg::BIT_IDX_W)'(DATA_BITS - 1))
                        err_o[0] <= 1'b1;
                end else if (count_bit_i != ((step_due && prev_idx != '0) ?
                                             prev_idx - 1'b1 : prev_idx)) begin
                    err_o[0] <= 1'b1;  // no step on an edge or a step without one
                end
            end else if (is_shift(prev_state) && prev_idx != '0) begin
                err_o[0] <= 1'b1;  // byte ended early
            end
            prev_idx <= count_bit_i;
        end
    end

endmodule

// ==== sim/i2c_golden.txt ====
# name rw addr_ack nack_mask(hex, bit i = data byte i+1) tx_bytes rx_space
# repeat_byte exp_pops exp_pushes exp_stops
wr_ack3      0 1 0 3 0 0 3 0 1
wr_addr_nack 0 0 0 3 0 0 0 0 1
wr_data_nack 0 1 2 4 0 0 2 0 1
wr_empty     0 1 0 0 0 0 0 0 1
rd_full2     1 1 0 0 2 0 0 2 1
rd_addr_nack 1 0 0 0 4 0 0 0 1
wr_repeat    0 1 0 4 0 2 4 0 1
rd_repeat    1 1 0 0 3 1 0 3 1
wr_ack1      0 1 0 1 0 0 1 0 1

// ==== sim/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;

    localparam int DATA_BITS   = 8;
    localparam int START_DELAY = 6;
    localparam int MAX_TESTS   = 16;

    logic i2c_core_clk = 1'b0;
    logic reset_ni;
    logic enable_i;
    logic rw_i;
    logic i2c_scl;
    logic i2c_sda;
    logic repeat_start;
    i2c_master_pkg::fifo_status_t fifo_status;
    i2c_master_pkg::line_ctrl_t   line_ctrl;
    i2c_master_pkg::fifo_strobe_t fifo_strobe;
    logic [i2c_master_pkg::BIT_IDX_W-1:0] count_bit;

    // per-test bus model setup
    logic        addr_ack;
    logic [15:0] nack_mask;
    int          tx_bytes, rx_space, rep_byte;
    int          pops, pushes, starts, stops;
    logic [1:0]  model_err;

    string t_name[MAX_TESTS];
    int    t_rw[MAX_TESTS], t_ack[MAX_TESTS], t_mask[MAX_TESTS], t_tx[MAX_TESTS];
    int    t_rx[MAX_TESTS], t_rep[MAX_TESTS], t_pops[MAX_TESTS], t_push[MAX_TESTS];
    int    t_stops[MAX_TESTS];
    int    n_tests, limit, cycles;
    string cur_test;

    i2c_master_top #(
        .DATA_BITS   (DATA_BITS),
        .START_DELAY (START_DELAY)
    ) u_i2c_master_top (
        .i2c_core_clk_i (i2c_core_clk),
        .reset_ni       (reset_ni),
        .enable_i       (enable_i),
        .repeat_start_i (repeat_start),
        .rw_i           (rw_i),
        .fifo_status_i  (fifo_status),
        .i2c_sda_i      (i2c_sda),
        .i2c_scl_i      (i2c_scl),
        .line_ctrl_o    (line_ctrl),
        .count_bit_o    (count_bit),
        .fifo_strobe_o  (fifo_strobe)
    );

    i2c_bus_model #(.DATA_BITS(DATA_BITS)) u_bus_model (
        .i2c_core_clk_i (i2c_core_clk),
        .reset_ni       (reset_ni),
        .state_i        (u_i2c_master_top.u_master_fsm.state_q),
        .line_ctrl_i    (line_ctrl),
        .fifo_strobe_i  (fifo_strobe),
        .count_bit_i    (count_bit),
        .addr_ack_i     (addr_ack),
        .nack_mask_i    (nack_mask),
        .tx_bytes_i     (tx_bytes),
        .rx_space_i     (rx_space),
        .rep_byte_i     (rep_byte),
        .i2c_scl_o      (i2c_scl),
        .i2c_sda_o      (i2c_sda),
        .repeat_start_o (repeat_start),
        .fifo_status_o  (fifo_status),
        .pops_o         (pops),
        .pushes_o       (pushes),
        .starts_o       (starts),
        .stops_o        (stops),
        .err_o          (model_err)
    );

    initial begin
        forever #50 i2c_core_clk = ~i2c_core_clk;  // 100 ns period
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string what, int expected, int actual);
        if (expected != actual)
            abort_run($sformatf("FAILED %s %s: expected %0d, actual %0d",
                                cur_test, what, expected, actual));
    endtask

    // ------------------------------
    // watchdogs
    always @(posedge i2c_core_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit)
            abort_run($sformatf("timeout in %s after %0d cycles", cur_test, cycles));
        if (model_err[0])
            abort_run($sformatf("bit index did not step down to 0 in %s", cur_test));
        if (model_err[1])
            abort_run($sformatf("START without sda low and line enables in %s", cur_test));
    end

    task automatic read_golden();
        int    fd;
        int    n;
        string line;
        string nm;
        fd = $fopen("sim/i2c_golden.txt", "r");
        if (fd == 0) abort_run("cannot open golden file sim/i2c_golden.txt");
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s %d %d %h %d %d %d %d %d %d", nm, t_rw[n_tests],
                        t_ack[n_tests], t_mask[n_tests], t_tx[n_tests], t_rx[n_tests],
                        t_rep[n_tests], t_pops[n_tests], t_push[n_tests], t_stops[n_tests]);
            if (n != 10) abort_run($sformatf("malformed golden line: %s", line));
            t_name[n_tests] = nm;
            n_tests++;
        end
        $fclose(fd);
    endtask

    task automatic check_idle_outputs(string when);
        check_value({when, " line_ctrl"}, 0, int'(line_ctrl));
        check_value({when, " strobes"}, 0, int'(fifo_strobe));
        check_value({when, " count_bit"}, DATA_BITS - 1, int'(count_bit));
    endtask

    task automatic run_test(int i);
        cur_test = t_name[i];
        @(posedge i2c_core_clk);
        reset_ni  <= 1'b0;
        enable_i  <= 1'b0;
        rw_i      <= t_rw[i][0];
        addr_ack  <= t_ack[i][0];
        nack_mask <= t_mask[i][15:0];
        tx_bytes  <= t_tx[i];
        rx_space  <= t_rx[i];
        rep_byte  <= t_rep[i];
        repeat (5) begin
            @(posedge i2c_core_clk);
            check_idle_outputs("reset");
        end
        reset_ni <= 1'b1;
        @(posedge i2c_core_clk);
        check_idle_outputs("after reset");
        enable_i <= 1'b1;
        // end of transaction is STOP handing back to idle
        do @(posedge i2c_core_clk); while (stops == 0 || line_ctrl.scl_en);
        enable_i <= 1'b0;
        repeat (20) @(posedge i2c_core_clk);
        check_value("pops", t_pops[i], pops);
        check_value("pushes", t_push[i], pushes);
        check_value("stops", t_stops[i], stops);
        check_value("starts", (t_rep[i] != 0) ? 2 : 1, starts);
    endtask

    // ------------------------------
    initial begin
        reset_ni  = 1'b0;
        enable_i  = 1'b0;
        rw_i      = 1'b0;
        addr_ack  = 1'b1;
        nack_mask = '0;
        tx_bytes  = 0;
        rx_space  = 0;
        rep_byte  = 0;
        cycles    = 0;
        limit     = 0;
        n_tests   = 0;
        cur_test  = "setup";
        read_golden();
        if (n_tests == 0) abort_run("golden file holds no tests");
        for (int i = 0; i < n_tests; i++)
            limit += (t_tx[i] + t_rx[i] + 3) * 9 * 8;  // 9 scl periods per byte
        limit += 200;
        for (int i = 0; i < n_tests; i++) run_test(i);
        $display("all tests passed");
        $finish;
    end

endmodule
